// ==== logic/exe_config.svh ====
// execute stage widths
`ifndef EXE_CONFIG_SVH
`define EXE_CONFIG_SVH

`define EXE_WORD_W      32  // data word
`define EXE_REG_NUM_W   5   // gpr index
`define EXE_FWD_SRC_N   4   // rf, upper exe, mem, wb
`define EXE_BYTE_LANES  4
`define EXE_LANE_W      2   // byte offset bits inside a word

// leading count scan
`define EXE_CL_STEP     2   // bits per clock
`define EXE_CL_COUNT_W  6   // holds 0 to 32

`endif

// ==== logic/exeDataPkg.sv ====
// execute data types
`include "exe_config.svh"

package exeDataPkg;

    typedef logic [`EXE_WORD_W-1:0]     wordT;
    typedef logic [`EXE_REG_NUM_W-1:0]  regNumT;    // 0 means no write
    typedef logic [`EXE_BYTE_LANES-1:0] byteEnT;

    // one hot, bit 0 rf, bit 1 upper exe, bit 2 mem, bit 3 wb
    typedef logic [`EXE_FWD_SRC_N-1:0]  fwdSelT;

    typedef logic [`EXE_CL_COUNT_W-1:0] clCountT;

endpackage

// ==== logic/exeOpPkg.sv ====
// execute operation codes
package exeOpPkg;

    // ADD and SUB trap on signed overflow
    typedef enum logic [3:0] {
        ADD, SUB, ADDU, SUBU,
        AND, OR, XOR, NOR,
        SLT, SLTU,
        SLL, SRL, SRA,
        LUI
    } aluOpE;

    typedef enum logic [1:0] {
        CL_NONE, CL_ONES, CL_ZEROS
    } clOpE;

    typedef enum logic [2:0] {
        M_B, M_BU, M_H, M_HU, M_W, M_L, M_R
    } memModeE;

    // lane select for the load aligner in mem
    typedef enum logic [3:0] {
        LS_B, LS_BU, LS_H, LS_HU, LS_W,
        LS_L0, LS_L1, LS_L2,
        LS_R1, LS_R2, LS_R3
    } loadSelE;

    typedef enum logic [4:0] {
        EXC_NONE = 5'h00,
        EXC_OV   = 5'h0c,
        EXC_ADEL = 5'h04,
        EXC_ADES = 5'h05
    } excCodeE;

endpackage

// ==== logic/exeStageCtrl.sv ====
// execute stage register and interlock
`timescale 1ns/1ns

module exeStageCtrl import exeDataPkg::*, exeOpPkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    inValid_i,
    input  logic    downAllowIn_i,
    input  logic    flush_i,
    input  logic    clDone_i,
    input  regNumT  writeNum_i,
    input  aluOpE   aluOp_i,
    input  clOpE    clOp_i,
    input  wordT    operand0_i,
    input  wordT    operand1_i,
    input  logic    op0IsReg_i,
    input  logic    op1IsReg_i,
    input  fwdSelT  fwdSel0_i,
    input  fwdSelT  fwdSel1_i,
    input  wordT    regData0_i,
    input  wordT    regData1_i,
    input  wordT    exeUpRes_i,
    input  wordT    memRes_i,
    input  wordT    wbData_i,
    input  logic    memReq_i,
    input  logic    memWrite_i,
    input  memModeE memMode_i,
    output logic    allowIn_o,
    output logic    outValid_o,
    output logic    fwdValid_o,
    output logic    clStart_o,
    output logic    clAbort_o,
    output regNumT  writeNumR_o,
    output aluOpE   aluOpR_o,
    output clOpE    clOpR_o,
    output wordT    operand0R_o,
    output wordT    operand1R_o,
    output logic    op0IsRegR_o,
    output logic    op1IsRegR_o,
    output fwdSelT  fwdSel0R_o,
    output fwdSelT  fwdSel1R_o,
    output wordT    regData0R_o,
    output wordT    regData1R_o,
    output wordT    exeUpResR_o,
    output wordT    memResR_o,
    output wordT    wbDataR_o,
    output logic    memReqR_o,
    output logic    memWriteR_o,
    output memModeE memModeR_o
);

    logic hasData;
    logic ready;
    logic accept;
    logic clStartR;

    ////////////////////
    // interlock

    // a count op blocks until its own result, not a stale done from the last one
    assign ready = (clOpR_o == CL_NONE) || (clDone_i && !clStartR);

    assign allowIn_o  = !hasData || (ready && downAllowIn_i);
    assign accept     = inValid_i && allowIn_o;
    assign outValid_o = hasData && ready && downAllowIn_i;
    assign fwdValid_o = hasData && ready && !memReqR_o;  // loads forward from mem
    assign clStart_o  = clStartR;
    assign clAbort_o  = flush_i;

    always_ff @(posedge clk) begin
        if (!rst) begin
            hasData  <= 1'b0;
            clStartR <= 1'b0;
        end else begin
            if (flush_i) begin
                hasData <= 1'b0;
            end else if (allowIn_o) begin
                hasData <= inValid_i;   // bubble when nothing arrives
            end
            clStartR <= accept && !flush_i && (clOp_i != CL_NONE);
        end
    end

    ////////////////////
    // stage register

    always_ff @(posedge clk) begin
        if (!rst) begin
            writeNumR_o <= '0;
            aluOpR_o    <= ADDU;
            clOpR_o     <= CL_NONE;
            op0IsRegR_o <= 1'b0;
            op1IsRegR_o <= 1'b0;
            fwdSel0R_o  <= '0;
            fwdSel1R_o  <= '0;
            memReqR_o   <= 1'b0;
            memWriteR_o <= 1'b0;
            memModeR_o  <= M_W;
        end else if (accept) begin
            writeNumR_o <= writeNum_i;
            aluOpR_o    <= aluOp_i;
            clOpR_o     <= clOp_i;
            op0IsRegR_o <= op0IsReg_i;
            op1IsRegR_o <= op1IsReg_i;
            fwdSel0R_o  <= fwdSel0_i;
            fwdSel1R_o  <= fwdSel1_i;
            memReqR_o   <= memReq_i;
            memWriteR_o <= memWrite_i;
            memModeR_o  <= memMode_i;
        end
    end

    // forward values are captured with the instruction
    always_ff @(posedge clk) begin
        if (accept) begin
            operand0R_o <= operand0_i;
            operand1R_o <= operand1_i;
            regData0R_o <= regData0_i;
            regData1R_o <= regData1_i;
            exeUpResR_o <= exeUpRes_i;
            memResR_o   <= memRes_i;
            wbDataR_o   <= wbData_i;
        end
    end

endmodule

// ==== logic/operandForward.sv ====
// operand forward select
`timescale 1ns/1ns
`include "exe_config.svh"

module operandForward import exeDataPkg::*; (
    input  fwdSelT fwdSel0_i,
    input  fwdSelT fwdSel1_i,
    input  logic   op0IsReg_i,
    input  logic   op1IsReg_i,
    input  wordT   operand0_i,
    input  wordT   operand1_i,
    input  wordT   regData0_i,
    input  wordT   regData1_i,
    input  wordT   exeUpRes_i,
    input  wordT   memRes_i,
    input  wordT   wbData_i,
    output wordT   src0_o,
    output wordT   src1_o,
    output wordT   storeVal_o
);

    wordT fwd0;
    wordT fwd1;

    // and-or merge over the one-hot select
    function automatic wordT fwdMerge(input fwdSelT sel, input wordT regData);
        wordT srcs [`EXE_FWD_SRC_N];
        wordT merged;
        srcs[0] = regData;
        srcs[1] = exeUpRes_i;
        srcs[2] = memRes_i;
        srcs[3] = wbData_i;
        merged  = '0;
        for (int i = 0; i < `EXE_FWD_SRC_N; i++) begin
            merged |= srcs[i] & {`EXE_WORD_W{sel[i]}};
        end
        return merged;
    endfunction

    always_comb begin
        fwd0 = fwdMerge(fwdSel0_i, regData0_i);
        fwd1 = fwdMerge(fwdSel1_i, regData1_i);
    end

    assign src0_o     = op0IsReg_i ? fwd0 : operand0_i;   // else immediate or sa
    assign src1_o     = op1IsReg_i ? fwd1 : operand1_i;
    assign storeVal_o = fwd1;                             // rt even when src1 is the offset

endmodule

// ==== logic/aluCore.sv ====
// execute ALU
`timescale 1ns/1ns
`include "exe_config.svh"

module aluCore import exeDataPkg::*, exeOpPkg::*; (
    input  aluOpE aluOp_i,
    input  wordT  src0_i,
    input  wordT  src1_i,
    output wordT  aluRes_o,
    output logic  overflow_o
);

    localparam int MSB = `EXE_WORD_W - 1;

    wordT sum;
    wordT diff;
    logic [$clog2(`EXE_WORD_W)-1:0] shamt;

    assign sum   = src0_i + src1_i;
    assign diff  = src0_i - src1_i;
    assign shamt = src0_i[$clog2(`EXE_WORD_W)-1:0];   // sa sits in operand 0

    always_comb begin
        case (aluOp_i)
            ADD, ADDU: aluRes_o = sum;
            SUB, SUBU: aluRes_o = diff;
            AND:       aluRes_o = src0_i & src1_i;
            OR:        aluRes_o = src0_i | src1_i;
            XOR:       aluRes_o = src0_i ^ src1_i;
            NOR:       aluRes_o = ~(src0_i | src1_i);
            SLT:       aluRes_o = wordT'($signed(src0_i) < $signed(src1_i));
            SLTU:      aluRes_o = wordT'(src0_i < src1_i);
            SLL:       aluRes_o = src1_i << shamt;
            SRL:       aluRes_o = src1_i >> shamt;
            SRA:       aluRes_o = wordT'($signed(src1_i) >>> shamt);
            LUI:       aluRes_o = {src1_i[15:0], 16'h0000};  // imm in operand 1
            default:   aluRes_o = '0;
        endcase
    end

    // same-sign add or opposite-sign sub whose result sign flips
    assign overflow_o =
        ((aluOp_i == ADD) && (src0_i[MSB] == src1_i[MSB]) && (sum[MSB] != src0_i[MSB])) ||
        ((aluOp_i == SUB) && (src0_i[MSB] != src1_i[MSB]) && (diff[MSB] != src0_i[MSB]));

endmodule

// ==== logic/memAccessPrep.sv ====
// memory access preparation
`timescale 1ns/1ns
`include "exe_config.svh"

module memAccessPrep import exeDataPkg::*, exeOpPkg::*; (
    input  logic                   memReq_i,
    input  logic                   memWrite_i,
    input  memModeE                memMode_i,
    input  logic [`EXE_LANE_W-1:0] addrLow_i,
    input  wordT                   storeVal_i,
    input  logic                   overflow_i,
    output byteEnT                 memEnable_o,
    output wordT                   storeData_o,
    output loadSelE                loadSel_o,
    output logic                   hasException_o,
    output excCodeE                excCode_o
);

    logic [`EXE_LANE_W-1:0] leftGap;
    logic                   misaligned;

    assign leftGap = ~addrLow_i;    // 3 - a

    ////////////////////
    // lanes and store data

    always_comb begin
        case (memMode_i)
            M_B, M_BU: begin
                memEnable_o = byteEnT'(1) << addrLow_i;
                storeData_o = {4{storeVal_i[7:0]}};
            end
            M_H, M_HU: begin
                memEnable_o = byteEnT'(2'b11) << addrLow_i;
                storeData_o = {2{storeVal_i[15:0]}};
            end
            M_L: begin  // swl fills lanes 0..a
                memEnable_o = {`EXE_BYTE_LANES{1'b1}} >> leftGap;
                storeData_o = storeVal_i >> {leftGap, 3'b000};
            end
            M_R: begin  // swr fills lanes a..3
                memEnable_o = {`EXE_BYTE_LANES{1'b1}} << addrLow_i;
                storeData_o = storeVal_i << {addrLow_i, 3'b000};
            end
            default: begin
                memEnable_o = '1;
                storeData_o = storeVal_i;
            end
        endcase
    end

    ////////////////////
    // load lane select

    always_comb begin
        case (memMode_i)
            M_B:  loadSel_o = LS_B;
            M_BU: loadSel_o = LS_BU;
            M_H:  loadSel_o = LS_H;
            M_HU: loadSel_o = LS_HU;
            M_L: begin
                case (addrLow_i)
                    2'd0:    loadSel_o = LS_L0;
                    2'd1:    loadSel_o = LS_L1;
                    2'd2:    loadSel_o = LS_L2;
                    default: loadSel_o = LS_W;  // full word at a=3
                endcase
            end
            M_R: begin
                case (addrLow_i)
                    2'd0:    loadSel_o = LS_W;
                    2'd1:    loadSel_o = LS_R1;
                    2'd2:    loadSel_o = LS_R2;
                    default: loadSel_o = LS_R3;
                endcase
            end
            default: loadSel_o = LS_W;
        endcase
    end

    // lwl/lwr and bytes never fault
    assign misaligned = ((memMode_i == M_H || memMode_i == M_HU) && addrLow_i[0]) ||
                        ((memMode_i == M_W) && (addrLow_i != '0));

    always_comb begin
        if (overflow_i) begin
            excCode_o = EXC_OV;
        end else if (memReq_i && misaligned) begin
            excCode_o = memWrite_i ? EXC_ADES : EXC_ADEL;
        end else begin
            excCode_o = EXC_NONE;
        end
    end

    assign hasException_o = (excCode_o != EXC_NONE);

endmodule

// ==== logic/countLeading.sv ====
// leading ones and zeros counter
`timescale 1ns/1ns
`include "exe_config.svh"

module countLeading import exeDataPkg::*, exeOpPkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    clStart_i,
    input  logic    clAbort_i,
    input  clOpE    clOp_i,
    input  wordT    value_i,
    output logic    clDone_o,
    output clCountT clCount_o
);

    typedef enum logic [1:0] {CL_IDLE, CL_BUSY, CL_DONE} clStateE;
    typedef logic [$clog2(`EXE_WORD_W)-1:0] bitPosT;

    clStateE state;
    bitPosT  bitPos;      // upper bit of the group in view
    logic    matching;    // no mismatch seen yet
    logic    matchNext;
    logic    target;
    clCountT addCnt;

    assign target = (clOp_i == CL_ONES);

    // add up the group until the first bit that differs
    always_comb begin
        addCnt    = '0;
        matchNext = matching;
        for (int k = 0; k < `EXE_CL_STEP; k++) begin
            if (matchNext && (value_i[bitPos - k] == target)) begin
                addCnt = addCnt + 1'b1;
            end else begin
                matchNext = 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst || clAbort_i) begin
            state <= CL_IDLE;
        end else begin
            case (state)
                CL_IDLE, CL_DONE: if (clStart_i) state <= CL_BUSY;
                CL_BUSY: if (bitPos == `EXE_CL_STEP - 1) state <= CL_DONE;
                default: state <= CL_IDLE;
            endcase
        end
    end

    // count stays put in done until the next start
    always_ff @(posedge clk) begin
        if (clStart_i) begin
            bitPos    <= '1;    // msb first
            matching  <= 1'b1;
            clCount_o <= '0;
        end else if (state == CL_BUSY) begin
            bitPos    <= bitPos - bitPosT'(`EXE_CL_STEP);
            matching  <= matchNext;
            clCount_o <= clCount_o + addCnt;
        end
    end

    assign clDone_o = (state == CL_DONE);

endmodule

// ==== logic/exeDownStage.sv ====
// lower execute stage
`timescale 1ns/1ns
`include "exe_config.svh"

module exeDownStage import exeDataPkg::*, exeOpPkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    inValid_i,
    input  regNumT  writeNum_i,
    input  aluOpE   aluOp_i,
    input  clOpE    clOp_i,
    input  wordT    operand0_i,
    input  wordT    operand1_i,
    input  logic    op0IsReg_i,
    input  logic    op1IsReg_i,
    input  fwdSelT  fwdSel0_i,
    input  fwdSelT  fwdSel1_i,
    input  wordT    regData0_i,
    input  wordT    regData1_i,
    input  wordT    exeUpRes_i,
    input  wordT    memRes_i,
    input  wordT    wbData_i,
    input  logic    memReq_i,
    input  logic    memWrite_i,
    input  memModeE memMode_i,
    input  logic    downAllowIn_i,
    input  logic    flush_i,
    output logic    allowIn_o,
    output logic    outValid_o,
    output logic    fwdValid_o,
    output wordT    result_o,
    output regNumT  writeNum_o,
    output logic    memReq_o,
    output logic    memWrite_o,
    output byteEnT  memEnable_o,
    output wordT    storeData_o,
    output loadSelE loadSel_o,
    output logic    hasException_o,
    output excCodeE excCode_o
);

    aluOpE   aluOpR;
    clOpE    clOpR;
    memModeE memModeR;
    wordT    operand0R, operand1R, regData0R, regData1R;
    wordT    exeUpResR, memResR, wbDataR;
    logic    op0IsRegR, op1IsRegR;
    fwdSelT  fwdSel0R, fwdSel1R;
    logic    clStart, clAbort, clDone;
    clCountT clCount;
    wordT    src0, src1, storeVal, aluRes;
    logic    overflow;

    ////////////////////
    // control

    exeStageCtrl u_ctrl (
        .clk, .rst, .inValid_i, .downAllowIn_i, .flush_i,
        .clDone_i(clDone),
        .writeNum_i, .aluOp_i, .clOp_i, .operand0_i, .operand1_i,
        .op0IsReg_i, .op1IsReg_i, .fwdSel0_i, .fwdSel1_i,
        .regData0_i, .regData1_i, .exeUpRes_i, .memRes_i, .wbData_i,
        .memReq_i, .memWrite_i, .memMode_i,
        .allowIn_o, .outValid_o, .fwdValid_o,
        .clStart_o(clStart),     .clAbort_o(clAbort),
        .writeNumR_o(writeNum_o), .aluOpR_o(aluOpR),     .clOpR_o(clOpR),
        .operand0R_o(operand0R), .operand1R_o(operand1R),
        .op0IsRegR_o(op0IsRegR), .op1IsRegR_o(op1IsRegR),
        .fwdSel0R_o(fwdSel0R),   .fwdSel1R_o(fwdSel1R),
        .regData0R_o(regData0R), .regData1R_o(regData1R),
        .exeUpResR_o(exeUpResR), .memResR_o(memResR),    .wbDataR_o(wbDataR),
        .memReqR_o(memReq_o),    .memWriteR_o(memWrite_o), .memModeR_o(memModeR)
    );

    ////////////////////
    // datapath

    operandForward u_fwd (
        .fwdSel0_i(fwdSel0R),   .fwdSel1_i(fwdSel1R),
        .op0IsReg_i(op0IsRegR), .op1IsReg_i(op1IsRegR),
        .operand0_i(operand0R), .operand1_i(operand1R),
        .regData0_i(regData0R), .regData1_i(regData1R),
        .exeUpRes_i(exeUpResR), .memRes_i(memResR), .wbData_i(wbDataR),
        .src0_o(src0), .src1_o(src1), .storeVal_o(storeVal)
    );

    aluCore u_alu (
        .aluOp_i(aluOpR), .src0_i(src0), .src1_i(src1),
        .aluRes_o(aluRes), .overflow_o(overflow)
    );

    memAccessPrep u_mem (
        .memReq_i(memReq_o),   .memWrite_i(memWrite_o), .memMode_i(memModeR),
        .addrLow_i(aluRes[`EXE_LANE_W-1:0]),
        .storeVal_i(storeVal), .overflow_i(overflow),
        .memEnable_o, .storeData_o, .loadSel_o, .hasException_o, .excCode_o
    );

    countLeading u_cl (
        .clk, .rst,
        .clStart_i(clStart), .clAbort_i(clAbort), .clOp_i(clOpR),
        .value_i(src0),      .clDone_o(clDone),   .clCount_o(clCount)
    );

    // clo/clz write the count, everything else the ALU word
    assign result_o = (clOpR != CL_NONE) ?
                      {{(`EXE_WORD_W - `EXE_CL_COUNT_W){1'b0}}, clCount} : aluRes;

endmodule

// ==== bench/exeDown_sva.sv ====
// stage interlock assertions
`timescale 1ns/1ns
`include "exe_config.svh"

module exeDown_sva import exeDataPkg::*, exeOpPkg::*; (
    input logic    clk,
    input logic    rst,
    input logic    flush_i,
    input logic    downAllowIn_i,
    input logic    allowIn_o,
    input logic    outValid_o,
    input logic    fwdValid_o,
    input wordT    result_o,
    input regNumT  writeNum_o,
    input byteEnT  memEnable_o,
    input wordT    storeData_o,
    input loadSelE loadSel_o,
    input excCodeE excCode_o
);

    int failCount = 0;  // assertion failures so far

    // empty stage right after a reset edge
    resetState: assert property (@(posedge clk) !rst |=> allowIn_o && !outValid_o)
        else begin
            $error("stage not empty after reset");
            failCount++;
        end

    // an occupied stage that cannot pass on stays occupied
    keepWhenBlocked: assert property (@(posedge clk) disable iff (!rst)
        (!allowIn_o && !flush_i) |=> (!allowIn_o || downAllowIn_i))
        else begin
            $error("stage emptied while its instruction was blocked");
            failCount++;
        end

    // a held instruction keeps its register-driven outputs
    holdFields: assert property (@(posedge clk) disable iff (!rst)
        (!allowIn_o && !downAllowIn_i && !flush_i) |=>
        $stable({writeNum_o, memEnable_o, storeData_o, loadSel_o, excCode_o}))
        else begin
            $error("held instruction outputs changed");
            failCount++;
        end

    holdResult: assert property (@(posedge clk) disable iff (!rst)
        (fwdValid_o && !downAllowIn_i && !flush_i) |=> $stable(result_o))
        else begin
            $error("held result changed");
            failCount++;
        end

    flushClears: assert property (@(posedge clk) disable iff (!rst)
        flush_i |=> !outValid_o)
        else begin
            $error("outValid_o high after flush");
            failCount++;
        end

endmodule

// ==== bench/exeDownChecker.sv ====
// result checker
`timescale 1ns/1ns
`include "exe_config.svh"

module exeDownChecker import exeDataPkg::*, exeOpPkg::*; (
    input logic    clk,
    input logic    rst,
    input logic    outValid_i,
    input logic    fwdValid_i,
    input wordT    result_i,
    input regNumT  writeNum_i,
    input logic    memReq_i,
    input logic    memWrite_i,
    input byteEnT  memEnable_i,
    input wordT    storeData_i,
    input loadSelE loadSel_i,
    input logic    hasException_i,
    input excCodeE excCode_i
);

    typedef struct packed {
        wordT    res;
        byteEnT  en;
        wordT    st;
        loadSelE ls;
        excCodeE exc;
        regNumT  wn;
        logic    req;
        logic    wr;
    } expT;

    expT expQ[$];   // oldest at the front
    int  errors = 0;
    int  checks = 0;

    task automatic pushExpect(input wordT res, input byteEnT en, input wordT st,
                              input loadSelE ls, input excCodeE exc, input regNumT wn,
                              input logic req, input logic wr);
        expT e;
        e = '{res, en, st, ls, exc, wn, req, wr};
        expQ.push_back(e);
    endtask

    function automatic int pending();
        return expQ.size();
    endfunction

    task automatic compareField(input string name, input logic [31:0] got,
                                input logic [31:0] want);
        if (got !== want) begin
            errors++;
            $display("ERROR %0t: %s got %h expected %h", $time, name, got, want);
        end
    endtask

    always @(posedge clk) begin
        if (rst && outValid_i) begin
            if (expQ.size() == 0) begin
                errors++;
                $display("an instruction came out at %0t with nothing left to expect", $time);
            end else begin
                expT e;
                e = expQ.pop_front();
                checks++;
                compareField("result", result_i, e.res);
                compareField("memEnable", 32'(memEnable_i), 32'(e.en));
                compareField("storeData", storeData_i, e.st);
                compareField("loadSel", 32'(loadSel_i), 32'(e.ls));
                compareField("excCode", 32'(excCode_i), 32'(e.exc));
                compareField("writeNum", 32'(writeNum_i), 32'(e.wn));
                compareField("memReq", 32'(memReq_i), 32'(e.req));
                compareField("memWrite", 32'(memWrite_i), 32'(e.wr));
                // any exception code raises the flag
                compareField("hasException", 32'(hasException_i), 32'(e.exc != EXC_NONE));
                // loads and stores never forward from this stage
                compareField("fwdValid", 32'(fwdValid_i), 32'(!e.req));
            end
        end
    end

    task automatic reportLeftover();
        if (expQ.size() != 0) begin
            $display("%0d expected results were never delivered", expQ.size());
        end
    endtask

endmodule

// ==== bench/exeDownTb.sv ====
// lower execute stage testbench
`timescale 1ns/1ns
`include "exe_config.svh"

module exeDownTb import exeDataPkg::*, exeOpPkg::*;;

    localparam wordT RF0 = 32'h1234_5678;
    localparam wordT RF1 = 32'ha1b2_c3d4;
    localparam wordT EXU = 32'h0000_0100;
    localparam wordT MEM = 32'hffff_fff0;
    localparam wordT WB  = 32'h7fff_ffff;

    typedef struct {
        aluOpE   aluOp;
        clOpE    clOp;
        wordT    op0;
        wordT    op1;
        logic    isReg0;
        logic    isReg1;
        fwdSelT  sel0;
        fwdSelT  sel1;
        logic    memReq;
        logic    memWrite;
        memModeE memMode;
        logic    flush;
        wordT    expRes;
        byteEnT  expEn;
        wordT    expSt;
        loadSelE expLs;
        excCodeE expExc;
    } rowT;

    rowT     rows[$];
    integer  seed = 32'hd73f_e121;
    int      cycles = 0;
    int      limit;

    logic    clk, rst, inValid, downAllowIn, flush;
    regNumT  writeNum;
    aluOpE   aluOp;
    clOpE    clOp;
    wordT    operand0, operand1;
    logic    op0IsReg, op1IsReg, memReq, memWrite;
    fwdSelT  fwdSel0, fwdSel1;
    memModeE memMode;
    logic    allowIn, outValid, fwdValid, memReqO, memWriteO, hasException;
    wordT    result, storeData;
    regNumT  writeNumO;
    byteEnT  memEnable;
    loadSelE loadSel;
    excCodeE excCode;

    exeDownStage dut0 (
        .clk, .rst, .inValid_i(inValid), .writeNum_i(writeNum),
        .aluOp_i(aluOp), .clOp_i(clOp), .operand0_i(operand0), .operand1_i(operand1),
        .op0IsReg_i(op0IsReg), .op1IsReg_i(op1IsReg),
        .fwdSel0_i(fwdSel0), .fwdSel1_i(fwdSel1),
        .regData0_i(RF0), .regData1_i(RF1), .exeUpRes_i(EXU), .memRes_i(MEM), .wbData_i(WB),
        .memReq_i(memReq), .memWrite_i(memWrite), .memMode_i(memMode),
        .downAllowIn_i(downAllowIn), .flush_i(flush),
        .allowIn_o(allowIn), .outValid_o(outValid), .fwdValid_o(fwdValid),
        .result_o(result), .writeNum_o(writeNumO), .memReq_o(memReqO),
        .memWrite_o(memWriteO), .memEnable_o(memEnable), .storeData_o(storeData),
        .loadSel_o(loadSel), .hasException_o(hasException), .excCode_o(excCode)
    );

    exeDownChecker chk0 (
        .clk, .rst, .outValid_i(outValid), .fwdValid_i(fwdValid), .result_i(result),
        .writeNum_i(writeNumO), .memReq_i(memReqO), .memWrite_i(memWriteO),
        .memEnable_i(memEnable), .storeData_i(storeData), .loadSel_i(loadSel),
        .hasException_i(hasException), .excCode_i(excCode)
    );

    bind exeDownStage exeDown_sva sva0 (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    ////////////////////
    // row builders

    task automatic addAluRow(input aluOpE op, input wordT a, input wordT b,
                             input logic r0, input logic r1, input fwdSelT s0,
                             input fwdSelT s1, input wordT res, input wordT st,
                             input excCodeE exc);
        rows.push_back('{op, CL_NONE, a, b, r0, r1, s0, s1, 1'b0, 1'b0, M_W, 1'b0,
                         res, 4'hf, st, LS_W, exc});
    endtask

    // base 0x1000 plus offset a, store value from rf
    task automatic addMemRow(input memModeE mode, input logic wr, input wordT a,
                             input byteEnT en, input wordT st, input loadSelE ls,
                             input excCodeE exc);
        rows.push_back('{ADDU, CL_NONE, 32'h1000, a, 1'b0, 1'b0, 4'b0000, 4'b0001,
                         1'b1, wr, mode, 1'b0, 32'h1000 + a, en, st, ls, exc});
    endtask

    task automatic addCountRow(input clOpE op, input wordT v, input logic r0,
                               input fwdSelT s0, input wordT cnt);
        rows.push_back('{ADDU, op, v, 32'h0, r0, 1'b0, s0, 4'b0000, 1'b0, 1'b0, M_W, 1'b0,
                         cnt, 4'hf, 32'h0, LS_W, EXC_NONE});
    endtask

    task automatic addFlushRow(input wordT a, input wordT b);
        rows.push_back('{ADDU, CL_NONE, a, b, 1'b0, 1'b0, 4'b0000, 4'b0000, 1'b0, 1'b0, M_W,
                         1'b1, 32'h0, 4'hf, 32'h0, LS_W, EXC_NONE});
    endtask

    task automatic buildRows();
        addAluRow(ADDU, 32'h5, 32'h7, 0, 0, 4'b0000, 4'b0000, 32'hc, 32'h0, EXC_NONE);
        addAluRow(ADDU, 32'h0, 32'h0, 1, 1, 4'b0001, 4'b0010, 32'h1234_5778, EXU, EXC_NONE);
        addAluRow(SUBU, 32'h0, 32'h0, 1, 1, 4'b0100, 4'b1000, 32'h7fff_fff1, WB, EXC_NONE);
        addAluRow(ADD, 32'h0, 32'h1, 1, 0, 4'b1000, 4'b0000, 32'h8000_0000, 32'h0, EXC_OV);
        addAluRow(ADDU, 32'h0, 32'h1, 1, 0, 4'b1000, 4'b0000, 32'h8000_0000, 32'h0, EXC_NONE);
        addAluRow(SUB, 32'h8000_0000, 32'h1, 0, 0, 4'b0, 4'b0, 32'h7fff_ffff, 32'h0, EXC_OV);
        addAluRow(SUBU, 32'h8000_0000, 32'h1, 0, 0, 4'b0, 4'b0, 32'h7fff_ffff, 32'h0,
                  EXC_NONE);
        addAluRow(ADD, 32'h3, 32'h0, 0, 1, 4'b0000, 4'b0100, 32'hffff_fff3, MEM, EXC_NONE);
        addAluRow(AND, 32'hf0f0_f0f0, 32'h0ff0_0ff0, 0, 0, 4'b0, 4'b0, 32'h00f0_00f0, 0, EXC_NONE);
        addAluRow(OR, 32'hf0f0_f0f0, 32'h0ff0_0ff0, 0, 0, 4'b0, 4'b0, 32'hfff0_fff0, 0, EXC_NONE);
        addAluRow(XOR, 32'hf0f0_f0f0, 32'h0ff0_0ff0, 0, 0, 4'b0, 4'b0, 32'hff00_ff00, 0, EXC_NONE);
        addAluRow(NOR, 32'hf0f0_f0f0, 32'h0ff0_0ff0, 0, 0, 4'b0, 4'b0, 32'h000f_000f, 0, EXC_NONE);
        addAluRow(SLT, 32'hffff_ffff, 32'h1, 0, 0, 4'b0, 4'b0, 32'h1, 32'h0, EXC_NONE);
        addAluRow(SLTU, 32'hffff_ffff, 32'h1, 0, 0, 4'b0, 4'b0, 32'h0, 32'h0, EXC_NONE);
        addAluRow(SLL, 32'h4, 32'h8765_4321, 0, 0, 4'b0, 4'b0, 32'h7654_3210, 0, EXC_NONE);
        addAluRow(SRL, 32'h8, 32'h8765_4321, 0, 0, 4'b0, 4'b0, 32'h0087_6543, 0, EXC_NONE);
        addAluRow(SRA, 32'h8, 32'h8765_4321, 0, 0, 4'b0, 4'b0, 32'hff87_6543, 0, EXC_NONE);
        addAluRow(LUI, 32'h0, 32'h0000_beef, 0, 0, 4'b0, 4'b0, 32'hbeef_0000, 0, EXC_NONE);
        addFlushRow(32'h1, 32'h1);
        addMemRow(M_B, 1, 32'h1, 4'b0010, 32'hd4d4_d4d4, LS_B, EXC_NONE);
        addMemRow(M_BU, 0, 32'h3, 4'b1000, 32'hd4d4_d4d4, LS_BU, EXC_NONE);
        addMemRow(M_H, 1, 32'h2, 4'b1100, 32'hc3d4_c3d4, LS_H, EXC_NONE);
        addMemRow(M_HU, 0, 32'h0, 4'b0011, 32'hc3d4_c3d4, LS_HU, EXC_NONE);
        addMemRow(M_H, 0, 32'h1, 4'b0110, 32'hc3d4_c3d4, LS_H, EXC_ADEL);
        addMemRow(M_H, 1, 32'h3, 4'b1000, 32'hc3d4_c3d4, LS_H, EXC_ADES);
        addMemRow(M_W, 1, 32'h0, 4'b1111, RF1, LS_W, EXC_NONE);
        addMemRow(M_W, 1, 32'h2, 4'b1111, RF1, LS_W, EXC_ADES);
        addMemRow(M_W, 0, 32'h3, 4'b1111, RF1, LS_W, EXC_ADEL);
        addMemRow(M_L, 1, 32'h0, 4'b0001, 32'h0000_00a1, LS_L0, EXC_NONE);
        addMemRow(M_L, 1, 32'h1, 4'b0011, 32'h0000_a1b2, LS_L1, EXC_NONE);
        addMemRow(M_L, 0, 32'h2, 4'b0111, 32'h00a1_b2c3, LS_L2, EXC_NONE);
        addMemRow(M_L, 0, 32'h3, 4'b1111, RF1, LS_W, EXC_NONE);
        addMemRow(M_R, 0, 32'h0, 4'b1111, RF1, LS_W, EXC_NONE);
        addMemRow(M_R, 1, 32'h1, 4'b1110, 32'hb2c3_d400, LS_R1, EXC_NONE);
        addMemRow(M_R, 0, 32'h2, 4'b1100, 32'hc3d4_0000, LS_R2, EXC_NONE);
        addMemRow(M_R, 1, 32'h3, 4'b1000, 32'hd400_0000, LS_R3, EXC_NONE);
        addCountRow(CL_ONES, 32'hfff0_0000, 0, 4'b0000, 32'd12);
        addCountRow(CL_ZEROS, 32'h0000_0001, 0, 4'b0000, 32'd31);
        addCountRow(CL_ZEROS, 32'h0, 0, 4'b0000, 32'd32);
        addCountRow(CL_ONES, 32'h7fff_ffff, 0, 4'b0000, 32'd0);
        addCountRow(CL_ONES, 32'h0, 1, 4'b0100, 32'd28);   // from the mem result
        addFlushRow(32'h5, 32'h6);
        addAluRow(ADDU, 32'h9, 32'h9, 0, 0, 4'b0000, 4'b0000, 32'd18, 32'h0, EXC_NONE);
    endtask

    ////////////////////
    // driving and reporting

    // drive on the falling edge, hold until accepted
    task automatic applyRow(input rowT r);
        inValid     = 1'b1;
        aluOp       = r.aluOp;
        clOp        = r.clOp;
        operand0    = r.op0;
        operand1    = r.op1;
        op0IsReg    = r.isReg0;
        op1IsReg    = r.isReg1;
        fwdSel0     = r.sel0;
        fwdSel1     = r.sel1;
        memReq      = r.memReq;
        memWrite    = r.memWrite;
        memMode     = r.memMode;
        downAllowIn = ($random(seed) & 3) != 0;
        #1;
        while (!allowIn) begin
            @(negedge clk);
            downAllowIn = ($random(seed) & 3) != 0;
            #1;
        end
        if (!r.flush) begin
            chk0.pushExpect(r.expRes, r.expEn, r.expSt, r.expLs, r.expExc, writeNum,
                            r.memReq, r.memWrite);
        end
        @(negedge clk);
        inValid = 1'b0;
        if (r.flush) begin
            flush       = 1'b1;
            downAllowIn = 1'b0;     // keep it from leaving before the flush edge
            @(negedge clk);
            flush = 1'b0;
        end
    endtask

    task automatic finishRun(input logic timedOut);
        int errs;
        errs = chk0.errors + dut0.sva0.failCount;
        chk0.reportLeftover();
        $display("checks %0d, errors %0d, assertion failures %0d, undelivered %0d",
                 chk0.checks, chk0.errors, dut0.sva0.failCount, chk0.pending());
        if (!timedOut && errs == 0 && chk0.pending() == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    endtask

    initial begin
        rst = 1'b0;
        inValid = 1'b0;
        downAllowIn = 1'b0;
        flush = 1'b0;
        writeNum = '0;
        aluOp = ADDU;
        clOp = CL_NONE;
        operand0 = '0;
        operand1 = '0;
        op0IsReg = 1'b0;
        op1IsReg = 1'b0;
        fwdSel0 = '0;
        fwdSel1 = '0;
        memReq = 1'b0;
        memWrite = 1'b0;
        memMode = M_W;
        buildRows();
        repeat (2) @(negedge clk);
        rst = 1'b1;
        foreach (rows[i]) begin
            writeNum = regNumT'(i);     // destination follows the row
            applyRow(rows[i]);
        end
        downAllowIn = 1'b1;     // drain the last one
        while (chk0.pending() != 0) begin
            @(negedge clk);
        end
        @(negedge clk);
        finishRun(1'b0);
    end

    // cycle limit scales with the table
    initial begin
        @(posedge clk);
        limit = rows.size() * 40;
        while (cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("run stopped after %0d cycles without finishing the table", limit);
        finishRun(1'b1);
    end

endmodule

// ==== verilog.f ====
+incdir+logic
logic/exeDataPkg.sv
logic/exeOpPkg.sv
logic/exeStageCtrl.sv
logic/operandForward.sv
logic/aluCore.sv
logic/memAccessPrep.sv
logic/countLeading.sv
logic/exeDownStage.sv
bench/exeDown_sva.sv
bench/exeDownChecker.sv
bench/exeDownTb.sv

// ==== Bender.yml ====
package:
  name: exe_down

sources:
  - include_dirs:
      - logic
    files:
      - logic/exeDataPkg.sv
      - logic/exeOpPkg.sv
      - logic/exeStageCtrl.sv
      - logic/operandForward.sv
      - logic/aluCore.sv
      - logic/memAccessPrep.sv
      - logic/countLeading.sv
      - logic/exeDownStage.sv
  - target: test
    include_dirs:
      - logic
    files:
      - bench/exeDown_sva.sv
      - bench/exeDownChecker.sv
      - bench/exeDownTb.sv
